/* hdl/fe_pkg.sv */
// Front end package
// Widths, command and queue encodings, and the stage records shared by
// the fetch front end and its testbench

package fe_pkg;

  localparam int vaddr_width_gp = 32;
  localparam int instr_width_gp = 32;

  // Wide enough for up to 16 banks
  localparam int bank_id_width_gp = 4;

  typedef enum logic [1:0]
  {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_imem_write  = 2'd2,
    e_op_wait        = 2'd3
  } fe_opcode_e;

  typedef struct packed
  {
    fe_opcode_e                opcode;
    logic [vaddr_width_gp-1:0] vaddr;
    logic [instr_width_gp-1:0] data;
  } fe_cmd_s;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic
  {
    e_instr_misaligned   = 1'b0,
    e_instr_access_fault = 1'b1
  } fe_exc_code_e;

  typedef struct packed
  {
    fe_msg_type_e              msg_type;
    logic [vaddr_width_gp-1:0] pc;
    logic [instr_width_gp-1:0] instr;
    fe_exc_code_e              exc_code;
  } fe_queue_s;

  typedef struct packed
  {
    logic                        valid;
    logic [vaddr_width_gp-1:0]   pc;
    logic [bank_id_width_gp-1:0] bank;
    logic                        misaligned;
    logic                        access_fault;
  } fe_if2_s;

  typedef struct packed
  {
    logic                      fail;
    logic [vaddr_width_gp-1:0] pc;
  } fe_fetch_status_s;

endpackage

/* hdl/fe_imem_bank.sv */
// Instruction memory bank
// One word-wide bank with a registered read port and a write port

`timescale 1ns/100ps

module fe_imem_bank
  import fe_pkg::*;
#(
  parameter int bank_words_p = 64,
  localparam int idx_bits_lp = $clog2(bank_words_p)
)
(
  input  logic                      clk_i,
  input  logic                      re_i,
  input  logic                      we_i,
  input  logic [idx_bits_lp-1:0]    idx_i,
  input  logic [instr_width_gp-1:0] w_data_i,
  output logic [instr_width_gp-1:0] r_data_o
);

  logic [instr_width_gp-1:0] mem [bank_words_p];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem[idx_i] <= w_data_i;
    // Read word holds until the next enabled read
    if (re_i)
      r_data_o <= mem[idx_i];
  end

endmodule

/* hdl/fe_bank_req.sv */
// Bank request decoder
// Splits fetch and write addresses into bank and index, flags faults,
// and holds the IF2 stage

`timescale 1ns/100ps

module fe_bank_req
  import fe_pkg::*;
#(
  parameter int num_banks_p  = 4,
  parameter int bank_words_p = 64,
  localparam int bank_bits_lp = $clog2(num_banks_p),
  localparam int idx_bits_lp  = $clog2(bank_words_p)
)
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      fetch_v_i,
  input  logic [vaddr_width_gp-1:0] fetch_pc_i,
  input  logic                      flush_i,

  input  logic                      mem_w_v_i,
  input  logic [vaddr_width_gp-1:0] mem_w_addr_i,

  output logic [num_banks_p-1:0]    bank_re_o,
  output logic [num_banks_p-1:0]    bank_we_o,
  output logic [idx_bits_lp-1:0]    bank_idx_o,
  output fe_if2_s                   if2_o
);

  localparam logic [vaddr_width_gp-1:0] mem_bytes_lp =
    vaddr_width_gp'(num_banks_p * bank_words_p * 4);

  // Low word bits pick the bank, the bits above pick the word
  wire [bank_bits_lp-1:0] f_bank = fetch_pc_i[2 +: bank_bits_lp];
  wire [idx_bits_lp-1:0]  f_idx  = fetch_pc_i[2 + bank_bits_lp +: idx_bits_lp];
  wire [bank_bits_lp-1:0] w_bank = mem_w_addr_i[2 +: bank_bits_lp];
  wire [idx_bits_lp-1:0]  w_idx  = mem_w_addr_i[2 + bank_bits_lp +: idx_bits_lp];

  wire f_misaligned = |fetch_pc_i[1:0];
  wire f_fault      = (fetch_pc_i >= mem_bytes_lp);
  wire f_ok         = fetch_v_i & ~f_misaligned & ~f_fault;

  // Writes only arrive on a command cycle
  wire w_sel = flush_i & mem_w_v_i;
  wire w_ok  = w_sel & (mem_w_addr_i < mem_bytes_lp);

  assign bank_idx_o = w_sel ? w_idx : f_idx;

  always_comb
  begin
    for (int i = 0; i < num_banks_p; i++)
    begin
      bank_re_o[i] = f_ok & (f_bank == bank_bits_lp'(i));
      bank_we_o[i] = w_ok & (w_bank == bank_bits_lp'(i));
    end
  end

  logic if2_v_r;
  logic [vaddr_width_gp-1:0]   if2_pc_r;
  logic [bank_id_width_gp-1:0] if2_bank_r;
  logic if2_misaligned_r, if2_fault_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if2_v_r <= 1'b0;
    else
      if2_v_r <= fetch_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
    begin
      if2_pc_r         <= fetch_pc_i;
      if2_bank_r       <= bank_id_width_gp'(f_bank);
      if2_misaligned_r <= f_misaligned;
      if2_fault_r      <= f_fault;
    end
  end

  assign if2_o = '{valid: if2_v_r, pc: if2_pc_r, bank: if2_bank_r,
                   misaligned: if2_misaligned_r, access_fault: if2_fault_r};

endmodule

/* hdl/fe_queue_out.sv */
// Fetch queue output stage
// Picks the IF2 bank word, formats the queue message and reports fetch
// failures back to the controller

`timescale 1ns/100ps

module fe_queue_out
  import fe_pkg::*;
#(
  parameter int num_banks_p = 4
)
(
  input  fe_if2_s                                    if2_i,
  input  logic [num_banks_p-1:0][instr_width_gp-1:0] bank_data_i,
  input  logic                                       flush_i,
  input  logic                                       fe_queue_ready_i,

  output fe_queue_s                                  fe_queue_o,
  output logic                                       fe_queue_v_o,
  output fe_fetch_status_s                           fetch_status_o
);

  logic [instr_width_gp-1:0] instr;
  logic exception_v;

  assign instr       = bank_data_i[if2_i.bank];
  assign exception_v = if2_i.misaligned | if2_i.access_fault;

  always_comb
  begin
    fe_queue_o    = '0;
    fe_queue_o.pc = if2_i.pc;
    if (exception_v)
    begin
      fe_queue_o.msg_type = e_fe_exception;
      // Misaligned wins when both flags are set
      fe_queue_o.exc_code = if2_i.misaligned ? e_instr_misaligned
                                             : e_instr_access_fault;
    end
    else
    begin
      fe_queue_o.msg_type = e_fe_fetch;
      fe_queue_o.instr    = instr;
    end
  end

  // Valid only while the queue can take the message
  assign fe_queue_v_o = if2_i.valid & fe_queue_ready_i & ~flush_i;

  // An IF2 item that is not delivered is replayed from its pc
  assign fetch_status_o.fail = if2_i.valid & ~fe_queue_v_o;
  assign fetch_status_o.pc   = if2_i.pc;

endmodule

/* hdl/fe_ctrl.sv */
// Front end controller
// Decodes commands, runs the wait/run/stall FSM and generates fetch PCs

`timescale 1ns/100ps

module fe_ctrl
  import fe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  fe_cmd_s                   fe_cmd_i,
  input  logic                      fe_cmd_v_i,
  output logic                      fe_cmd_yumi_o,

  input  fe_fetch_status_s          fetch_status_i,
  input  logic                      fe_queue_ready_i,

  output logic                      flush_o,
  output logic                      fetch_v_o,
  output logic [vaddr_width_gp-1:0] fetch_pc_o,

  output logic                      mem_w_v_o,
  output logic [vaddr_width_gp-1:0] mem_w_addr_o,
  output logic [instr_width_gp-1:0] mem_w_data_o
);

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  fe_state_e state_r, state_n;

  // Holds the next sequential pc while running, the resume pc otherwise
  logic [vaddr_width_gp-1:0] pc_r, pc_n;

  logic cmd_v;
  logic state_reset_v;
  logic redirect_v;
  logic imem_write_v;
  logic wait_v;

  // Every command is taken in the cycle it is offered
  assign cmd_v         = fe_cmd_v_i & ~reset_i;
  assign fe_cmd_yumi_o = cmd_v;
  assign flush_o       = cmd_v;

  assign state_reset_v = cmd_v & (fe_cmd_i.opcode == e_op_state_reset);
  assign redirect_v    = cmd_v & (fe_cmd_i.opcode == e_op_pc_redirect);
  assign imem_write_v  = cmd_v & (fe_cmd_i.opcode == e_op_imem_write);
  assign wait_v        = cmd_v & (fe_cmd_i.opcode == e_op_wait);

  assign mem_w_v_o    = imem_write_v;
  assign mem_w_addr_o = fe_cmd_i.vaddr;
  assign mem_w_data_o = fe_cmd_i.data;

  // A redirect fetches its own vaddr in the command cycle
  assign fetch_v_o  = (state_n == e_run);
  assign fetch_pc_o = redirect_v ? fe_cmd_i.vaddr : pc_r;

  always_comb
  begin
    state_n = state_r;
    if (redirect_v)
    begin
      state_n = e_run;
    end
    else if (state_reset_v)
    begin
      state_n = e_stall;
    end
    else if (imem_write_v | wait_v)
    begin
      state_n = e_wait;
    end
    else if (fetch_status_i.fail)
    begin
      state_n = e_stall;
    end
    else
    begin
      case (state_r)
        e_wait:  state_n = e_wait;
        e_run:   state_n = e_run;
        e_stall: state_n = fe_queue_ready_i ? e_run : e_stall;
        default: state_n = e_wait;
      endcase
    end
  end

  always_comb
  begin
    pc_n = pc_r;
    if (fetch_v_o)
    begin
      pc_n = fetch_pc_o + vaddr_width_gp'(4);
    end
    else if (state_reset_v)
    begin
      pc_n = fe_cmd_i.vaddr;
    end
    // Replay starts from the item that missed the queue
    else if (!cmd_v && fetch_status_i.fail)
    begin
      pc_n = fetch_status_i.pc;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
      pc_r    <= '0;
    end
    else
    begin
      state_r <= state_n;
      pc_r    <= pc_n;
    end
  end

endmodule

/* hdl/fe_top.sv */
// Instruction fetch front end
// Command-driven fetch controller over a word-interleaved instruction memory

`timescale 1ns/100ps

module fe_top
  import fe_pkg::*;
#(
  parameter int num_banks_p  = 4,
  parameter int bank_words_p = 64
)
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  fe_cmd_s   fe_cmd_i,
  input  logic      fe_cmd_v_i,
  output logic      fe_cmd_yumi_o,

  output fe_queue_s fe_queue_o,
  output logic      fe_queue_v_o,
  input  logic      fe_queue_ready_i
);

  localparam int idx_width_lp = $clog2(bank_words_p);

  logic                      flush;
  logic                      fetch_v;
  logic [vaddr_width_gp-1:0] fetch_pc;
  logic                      mem_w_v;
  logic [vaddr_width_gp-1:0] mem_w_addr;
  logic [instr_width_gp-1:0] mem_w_data;
  fe_fetch_status_s          fetch_status;
  fe_if2_s                   if2;

  logic [num_banks_p-1:0]                     bank_re;
  logic [num_banks_p-1:0]                     bank_we;
  logic [idx_width_lp-1:0]                    bank_idx;
  logic [num_banks_p-1:0][instr_width_gp-1:0] bank_data;

  fe_ctrl ctrl
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .fetch_status_i   (fetch_status),
    .fe_queue_ready_i (fe_queue_ready_i),
    .flush_o          (flush),
    .fetch_v_o        (fetch_v),
    .fetch_pc_o       (fetch_pc),
    .mem_w_v_o        (mem_w_v),
    .mem_w_addr_o     (mem_w_addr),
    .mem_w_data_o     (mem_w_data)
  );

  fe_bank_req #(.num_banks_p(num_banks_p), .bank_words_p(bank_words_p)) bank_req
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_v_i    (fetch_v),
    .fetch_pc_i   (fetch_pc),
    .flush_i      (flush),
    .mem_w_v_i    (mem_w_v),
    .mem_w_addr_i (mem_w_addr),
    .bank_re_o    (bank_re),
    .bank_we_o    (bank_we),
    .bank_idx_o   (bank_idx),
    .if2_o        (if2)
  );

  for (genvar i = 0; i < num_banks_p; i++)
  begin : g_bank
    fe_imem_bank #(.bank_words_p(bank_words_p)) bank
    (
      .clk_i    (clk_i),
      .re_i     (bank_re[i]),
      .we_i     (bank_we[i]),
      .idx_i    (bank_idx),
      .w_data_i (mem_w_data),
      .r_data_o (bank_data[i])
    );
  end

  fe_queue_out #(.num_banks_p(num_banks_p)) queue_out
  (
    .if2_i            (if2),
    .bank_data_i      (bank_data),
    .flush_i          (flush),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fetch_status_o   (fetch_status)
  );

endmodule

/* tests/fe_props.sv */
// Front end port properties
// Queue and command port rules, bound into the fetch front end top

`timescale 1ns/100ps

module fe_props
  import fe_pkg::*;
(
  input logic clk_i,
  input logic reset_i,
  input logic fe_cmd_v_i,
  input logic fe_cmd_yumi_o,
  input logic fe_queue_v_o,
  input logic fe_queue_ready_i
);

  // The queue port only presents a message while it can be taken
  a_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i)
    else $error("queue valid raised while ready is low");

  a_yumi_follows_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_o == fe_cmd_v_i)
    else $error("command yumi differs from command valid");

  a_quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !fe_queue_v_o)
    else $error("queue valid in the cycle after reset");

endmodule

bind fe_top fe_props props0
(
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .fe_cmd_v_i       (fe_cmd_v_i),
  .fe_cmd_yumi_o    (fe_cmd_yumi_o),
  .fe_queue_v_o     (fe_queue_v_o),
  .fe_queue_ready_i (fe_queue_ready_i)
);

/* tests/fe_tb.sv */
// Fetch front end testbench
// Fills the instruction memory, runs fetch streams under commands and
// back-pressure, and checks every queue delivery against a memory model

`timescale 1ns/100ps

module fe_tb
  import fe_pkg::*;
;

  localparam int num_banks_lp    = 4;
  localparam int bank_words_lp   = 64;
  localparam int num_words_lp    = num_banks_lp * bank_words_lp;
  localparam int word_bits_lp    = $clog2(num_words_lp);
  localparam logic [31:0] mem_bytes_lp = 32'(num_words_lp * 4);

  // Cycle budget of each test, in test order
  localparam int test_len_total_lp = 64 + 480 + 60 + 120 + 120;
  localparam int timeout_cycles_lp = test_len_total_lp * 4;

  logic      clk_i;
  logic      reset_i;
  fe_cmd_s   fe_cmd_i;
  logic      fe_cmd_v_i;
  logic      fe_cmd_yumi_o;
  fe_queue_s fe_queue_o;
  logic      fe_queue_v_o;
  logic      fe_queue_ready_i;

  logic [instr_width_gp-1:0] model [num_words_lp];
  logic [31:0]               rng_state;
  logic [31:0]               ready_draw;
  logic                      random_ready;
  logic                      stream_live;
  logic [31:0]               expect_pc;
  fe_queue_s                 last_msg;
  int delivered;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int cycle_count;

  fe_top #(.num_banks_p(num_banks_lp), .bank_words_p(bank_words_lp)) dut0
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Expected queue message for a pc, from the memory model and fault rules
  function automatic fe_queue_s expected_msg(input logic [31:0] pc);
    fe_queue_s m;
    m    = '0;
    m.pc = pc;
    if (pc[1:0] != 2'b00)
    begin
      m.msg_type = e_fe_exception;
      m.exc_code = e_instr_misaligned;
    end
    else if (pc >= mem_bytes_lp)
    begin
      m.msg_type = e_fe_exception;
      m.exc_code = e_instr_access_fault;
    end
    else
    begin
      m.msg_type = e_fe_fetch;
      m.instr    = model[pc[2 +: word_bits_lp]];
    end
    return m;
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called at a falling edge, returns one falling edge later
  task automatic send_cmd(input fe_opcode_e op, input logic [31:0] vaddr,
                          input logic [31:0] data);
    fe_cmd_i.opcode = op;
    fe_cmd_i.vaddr  = vaddr;
    fe_cmd_i.data   = data;
    fe_cmd_v_i      = 1'b1;
    if (op == e_op_imem_write && vaddr < mem_bytes_lp)
      model[vaddr[2 +: word_bits_lp]] = data;
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic wait_for_deliveries(input int n);
    int target;
    target = delivered + n;
    while (delivered < target)
      @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  // Ready is held high unless the random pattern is switched on
  always @(negedge clk_i)
  begin
    if (random_ready)
    begin
      ready_draw       = next_rand();
      fe_queue_ready_i = ready_draw[18];
    end
    else
      fe_queue_ready_i = 1'b1;
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (fe_queue_v_o)
      begin
        if (!stream_live)
        begin
          $display("Unexpected delivery of pc %h while fetch is stopped, time %0t",
                   fe_queue_o.pc, $time);
          errors++;
        end
        else
          check_value(128'(fe_queue_o), 128'(expected_msg(expect_pc)), "queue message");
        last_msg  = fe_queue_o;
        expect_pc = expect_pc + 32'd4;
        delivered++;
      end
      if (fe_cmd_v_i && fe_cmd_yumi_o)
      begin
        if (fe_cmd_i.opcode == e_op_pc_redirect || fe_cmd_i.opcode == e_op_state_reset)
        begin
          stream_live = 1'b1;
          expect_pc   = fe_cmd_i.vaddr;
        end
        else
          stream_live = 1'b0;
      end
    end
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles_lp)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    int start_err;
    int held;
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b1;
    rng_state        = 32'hd31464a8;
    random_ready     = 1'b0;
    stream_live      = 1'b0;
    expect_pc        = '0;
    last_msg         = '0;
    delivered        = 0;
    errors           = 0;
    checks           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;

    start_err = errors;
    for (int i = 0; i < 32; i++)
      send_cmd(e_op_imem_write, 32'(i * 4), next_rand());
    send_cmd(e_op_pc_redirect, 32'h0, '0);
    wait_for_deliveries(24);
    send_cmd(e_op_wait, '0, '0);
    report_test("sequential fetch", start_err);

    start_err = errors;
    for (int i = 32; i < num_words_lp; i++)
      send_cmd(e_op_imem_write, 32'(i * 4), next_rand());
    random_ready <= 1'b1;
    send_cmd(e_op_pc_redirect, next_rand() & 32'h1fc, '0);
    wait_for_deliveries(60);
    send_cmd(e_op_wait, '0, '0);
    random_ready <= 1'b0;
    report_test("random back-pressure", start_err);

    start_err = errors;
    send_cmd(e_op_pc_redirect, 32'h6, '0);
    wait_for_deliveries(1);
    check_value(128'(last_msg.msg_type), 128'(e_fe_exception), "misaligned type");
    check_value(128'(last_msg.exc_code), 128'(e_instr_misaligned), "misaligned code");
    send_cmd(e_op_pc_redirect, mem_bytes_lp, '0);
    wait_for_deliveries(1);
    check_value(128'(last_msg.msg_type), 128'(e_fe_exception), "fault type");
    check_value(128'(last_msg.exc_code), 128'(e_instr_access_fault), "fault code");
    // Stream that runs off the top of memory
    send_cmd(e_op_pc_redirect, mem_bytes_lp - 32'd16, '0);
    wait_for_deliveries(6);
    send_cmd(e_op_wait, '0, '0);
    report_test("fetch exceptions", start_err);

    start_err = errors;
    random_ready <= 1'b1;
    send_cmd(e_op_pc_redirect, 32'h40, '0);
    wait_for_deliveries(10);
    send_cmd(e_op_pc_redirect, 32'h200, '0);
    wait_for_deliveries(10);
    send_cmd(e_op_pc_redirect, 32'h80, '0);
    send_cmd(e_op_pc_redirect, 32'h300, '0);
    wait_for_deliveries(10);
    send_cmd(e_op_wait, '0, '0);
    random_ready <= 1'b0;
    report_test("redirect mid-stream", start_err);

    start_err = errors;
    send_cmd(e_op_pc_redirect, 32'h0, '0);
    wait_for_deliveries(4);
    send_cmd(e_op_wait, '0, '0);
    held = delivered;
    repeat (20) @(negedge clk_i);
    check_value(128'(delivered), 128'(held), "deliveries after wait");
    send_cmd(e_op_pc_redirect, 32'h20, '0);
    wait_for_deliveries(4);
    send_cmd(e_op_imem_write, mem_bytes_lp - 32'd4, next_rand());
    held = delivered;
    repeat (20) @(negedge clk_i);
    check_value(128'(delivered), 128'(held), "deliveries after memory write");
    send_cmd(e_op_state_reset, mem_bytes_lp - 32'd16, '0);
    wait_for_deliveries(6);
    send_cmd(e_op_wait, '0, '0);
    report_test("stop and resume", start_err);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* fe_top.f */
hdl/fe_pkg.sv
hdl/fe_imem_bank.sv
hdl/fe_bank_req.sv
hdl/fe_queue_out.sv
hdl/fe_ctrl.sv
hdl/fe_top.sv
tests/fe_props.sv
tests/fe_tb.sv

/* run.sh */
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --assert -Wno-fatal \
  --top-module fe_tb \
  -f fe_top.f

output=$(./obj_dir/Vfe_tb || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Regression passed"; then
  exit 0
else
  exit 1
fi
